//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int NB_DATA   = 32;
    localparam int NB_REG    = 5;
    localparam int NB_IMM    = 16;
    localparam int NB_OPCODE = 6;

    typedef logic [NB_DATA-1:0] data_t;
    typedef logic [NB_REG-1:0]  reg_idx_t;

    typedef enum logic [NB_OPCODE-1:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    typedef enum logic [NB_OPCODE-1:0] {
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic [NB_OPCODE-1:0] opcode;
        reg_idx_t             rs;
        reg_idx_t             rt;
        reg_idx_t             rd;
        logic [4:0]           shamt;
        logic [NB_OPCODE-1:0] funct;
    } r_view_t;

    typedef struct packed {
        logic [NB_OPCODE-1:0] opcode;
        reg_idx_t             rs;
        reg_idx_t             rt;
        logic [NB_IMM-1:0]    imm;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        instr_u instr;
        data_t  npc;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        data_t    rs_data;
        data_t    rt_data;
        data_t    imm;
        data_t    npc;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        data_t    alu_result;
        data_t    store_data;
        data_t    branch_target;
        logic     zero;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        logic     halt;
        data_t    data;
        reg_idx_t rd;
    } mem_wb_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        data_t    data;
    } wb_t;

endpackage

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter int IM_ADDR_W = 8
) (
    input  wire                   i_clock,
    input  wire                   i_arst_n,
    input  wire                   i_stall,
    input  wire                   i_hold,
    input  wire                   i_flush,
    input  wire mips_pkg::data_t  i_branch_target,
    input  wire                   i_im_we,
    input  wire [IM_ADDR_W-1:0]   i_im_addr,
    input  wire mips_pkg::data_t  i_im_data,
    output mips_pkg::if_id_t      o_if_id
);
    import mips_pkg::*;

    data_t  imem [2**IM_ADDR_W];
    data_t  pc;
    data_t  pc_plus1;
    if_id_t if_id_q;

    assign pc_plus1 = pc + 1'b1;   // Word addressed

    always_ff @(posedge i_clock) begin
        if (i_im_we) begin
            imem[i_im_addr] <= i_im_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= '0;
            if_id_q <= '0;
        end else if (i_flush) begin
            pc      <= i_branch_target;
            if_id_q <= '0;                      // NOP
        end else if (!(i_stall || i_hold)) begin
            pc            <= pc_plus1;
            if_id_q.instr <= imem[pc[IM_ADDR_W-1:0]];
            if_id_q.npc   <= pc_plus1;
        end
    end

    assign o_if_id = if_id_q;

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire                     i_clock,
    input  wire                     i_arst_n,
    input  wire mips_pkg::wb_t      i_wb,
    input  wire mips_pkg::reg_idx_t i_rs_addr,
    input  wire mips_pkg::reg_idx_t i_rt_addr,
    input  wire mips_pkg::reg_idx_t i_dbg_addr,
    output mips_pkg::data_t         o_rs_data,
    output mips_pkg::data_t         o_rt_data,
    output mips_pkg::data_t         o_dbg_data
);
    import mips_pkg::*;

    localparam int N_REGS = 2 ** NB_REG;

    data_t regs [N_REGS];

    // Write-through so decode sees the value retiring this cycle
    function automatic data_t read_port(input reg_idx_t addr);
        data_t value;
        if (addr == '0) begin
            value = '0;
        end else if (i_wb.we && (i_wb.rd == addr)) begin
            value = i_wb.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we && (i_wb.rd != '0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    always_comb begin
        o_rs_data  = read_port(i_rs_addr);
        o_rt_data  = read_port(i_rt_addr);
        o_dbg_data = read_port(i_dbg_addr);
    end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                     i_clock,
    input  wire                     i_arst_n,
    input  wire mips_pkg::if_id_t   i_if_id,
    input  wire mips_pkg::wb_t      i_wb,
    input  wire                     i_stall,
    input  wire                     i_flush,
    input  wire mips_pkg::reg_idx_t i_dbg_rb_addr,
    output mips_pkg::id_ex_t        o_id_ex,
    output logic                    o_halt_in_id,
    output mips_pkg::data_t         o_dbg_rb_data
);
    import mips_pkg::*;

    instr_u   instr;
    ctrl_t    ctrl;
    reg_idx_t dest;
    data_t    rs_data;
    data_t    rt_data;
    data_t    imm_ext;
    id_ex_t   id_ex_q;

    assign instr = i_if_id.instr;

    register_file u_register_file (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_wb       (i_wb),
        .i_rs_addr  (instr.i.rs),
        .i_rt_addr  (instr.i.rt),
        .i_dbg_addr (i_dbg_rb_addr),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_rb_data)
    );

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        case (instr.i.opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    F_ADDU:  ctrl.alu_op = ALU_ADD;
                    F_SUBU:  ctrl.alu_op = ALU_SUB;
                    F_AND:   ctrl.alu_op = ALU_AND;
                    F_OR:    ctrl.alu_op = ALU_OR;
                    F_XOR:   ctrl.alu_op = ALU_XOR;
                    F_SLT:   ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;   // NOP and unknown functs
                endcase
            end
            OP_ADDI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OP_LW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BEQ: begin
                ctrl.alu_op = ALU_SUB;    // Zero flag compares rs and rt
                ctrl.branch = 1'b1;
            end
            OP_HALT: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    assign dest         = (instr.r.opcode == OP_RTYPE) ? instr.r.rd : instr.i.rt;
    assign imm_ext      = {{(NB_DATA-NB_IMM){instr.i.imm[NB_IMM-1]}}, instr.i.imm};
    assign o_halt_in_id = (instr.i.opcode == OP_HALT);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            id_ex_q <= '0;
        end else if (i_stall || i_flush) begin
            id_ex_q <= '0;    // Bubble
        end else begin
            id_ex_q <= '{ctrl:    ctrl,
                         rs_data: rs_data,
                         rt_data: rt_data,
                         imm:     imm_ext,
                         npc:     i_if_id.npc,
                         rs:      instr.i.rs,
                         rt:      instr.i.rt,
                         rd:      dest};
        end
    end

    assign o_id_ex = id_ex_q;

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                     i_clock,
    input  wire                     i_arst_n,
    input  wire mips_pkg::id_ex_t   i_id_ex,
    input  wire mips_pkg::fwd_sel_e i_fwd_a,
    input  wire mips_pkg::fwd_sel_e i_fwd_b,
    input  wire mips_pkg::wb_t      i_wb,
    input  wire                     i_flush,
    output mips_pkg::ex_mem_t       o_ex_mem
);
    import mips_pkg::*;

    ex_mem_t ex_mem_q;
    data_t   op_a;
    data_t   rt_fwd;
    data_t   op_b;
    data_t   alu_result;

    function automatic data_t fwd_mux(input fwd_sel_e sel, input data_t reg_val,
                                      input data_t mem_val, input data_t wb_val);
        data_t value;
        case (sel)
            FWD_MEM: value = mem_val;
            FWD_WB:  value = wb_val;
            default: value = reg_val;
        endcase
        return value;
    endfunction

    assign op_a   = fwd_mux(i_fwd_a, i_id_ex.rs_data, ex_mem_q.alu_result, i_wb.data);
    assign rt_fwd = fwd_mux(i_fwd_b, i_id_ex.rt_data, ex_mem_q.alu_result, i_wb.data);
    assign op_b   = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : rt_fwd;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(NB_DATA-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_mem_q <= '0;
        end else if (i_flush) begin
            ex_mem_q <= '0;    // Squash younger instr
        end else begin
            ex_mem_q.ctrl          <= i_id_ex.ctrl;
            ex_mem_q.alu_result    <= alu_result;
            ex_mem_q.store_data    <= rt_fwd;                      // SW data after forwarding
            ex_mem_q.branch_target <= i_id_ex.npc + i_id_ex.imm;
            ex_mem_q.zero          <= (alu_result == '0);
            ex_mem_q.rd            <= i_id_ex.rd;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

`default_nettype wire

//--- rtl/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage #(
    parameter int DM_ADDR_W = 5
) (
    input  wire                    i_clock,
    input  wire                    i_arst_n,
    input  wire mips_pkg::ex_mem_t i_ex_mem,
    input  wire [DM_ADDR_W-1:0]    i_dm_addr,
    output logic                   o_branch_taken,
    output mips_pkg::data_t        o_branch_target,
    output mips_pkg::wb_t          o_wb,
    output logic                   o_hlt,
    output mips_pkg::data_t        o_dm_data
);
    import mips_pkg::*;

    localparam int DM_DEPTH = 2 ** DM_ADDR_W;

    data_t                dmem [DM_DEPTH];
    logic [DM_ADDR_W-1:0] dm_addr;
    data_t                load_data;
    mem_wb_t              mem_wb_q;
    logic                 hlt_q;

    assign dm_addr   = i_ex_mem.alu_result[DM_ADDR_W-1:0];   // Word index
    assign load_data = dmem[dm_addr];

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_ex_mem.ctrl.mem_write) begin
            dmem[dm_addr] <= i_ex_mem.store_data;
        end
    end

    assign o_branch_taken  = i_ex_mem.ctrl.branch & i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.branch_target;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_wb_q <= '0;
            hlt_q    <= 1'b0;
        end else begin
            mem_wb_q.reg_write <= i_ex_mem.ctrl.reg_write;
            mem_wb_q.halt      <= i_ex_mem.ctrl.halt;
            mem_wb_q.data      <= i_ex_mem.ctrl.mem_read ? load_data : i_ex_mem.alu_result;
            mem_wb_q.rd        <= i_ex_mem.rd;
            hlt_q              <= hlt_q | mem_wb_q.halt;   // Sticky until reset
        end
    end

    assign o_wb      = '{we: mem_wb_q.reg_write, rd: mem_wb_q.rd, data: mem_wb_q.data};
    assign o_hlt     = hlt_q | mem_wb_q.halt;
    assign o_dm_data = dmem[i_dm_addr];

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  wire mips_pkg::if_id_t  i_if_id,
    input  wire mips_pkg::id_ex_t  i_id_ex,
    input  wire mips_pkg::ex_mem_t i_ex_mem,
    input  wire mips_pkg::wb_t     i_wb,
    input  wire                    i_branch_taken,
    input  wire                    i_halt_in_id,
    output mips_pkg::fwd_sel_e     o_fwd_a,
    output mips_pkg::fwd_sel_e     o_fwd_b,
    output logic                   o_stall,
    output logic                   o_hold,
    output logic                   o_flush
);
    import mips_pkg::*;

    logic     mem_fwd_ok;
    logic     wb_fwd_ok;
    reg_idx_t id_rs;
    reg_idx_t id_rt;

    assign mem_fwd_ok = i_ex_mem.ctrl.reg_write && (i_ex_mem.rd != '0);
    assign wb_fwd_ok  = i_wb.we && (i_wb.rd != '0);

    function automatic fwd_sel_e pick_source(input reg_idx_t src);
        fwd_sel_e sel;
        if (mem_fwd_ok && (i_ex_mem.rd == src)) begin
            sel = FWD_MEM;    // Newer producer wins
        end else if (wb_fwd_ok && (i_wb.rd == src)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd_a = pick_source(i_id_ex.rs);
        o_fwd_b = pick_source(i_id_ex.rt);
    end

    assign id_rs = i_if_id.instr.i.rs;
    assign id_rt = i_if_id.instr.i.rt;

    // Load result not ready until MEM/WB, one bubble needed
    assign o_stall = i_id_ex.ctrl.mem_read && (i_id_ex.rd != '0) &&
                     ((i_id_ex.rd == id_rs) || (i_id_ex.rd == id_rt));

    assign o_hold  = i_halt_in_id;
    assign o_flush = i_branch_taken;   // Taken BEQ in EX/MEM

endmodule

`default_nettype wire

//--- rtl/mips_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module mips_pipeline #(
    parameter int IM_ADDR_W = 8,
    parameter int DM_ADDR_W = 5
) (
    input  wire                     i_clock,
    input  wire                     i_arst_n,
    input  wire                     i_im_we,
    input  wire [IM_ADDR_W-1:0]     i_im_addr,
    input  wire mips_pkg::data_t    i_im_data,
    input  wire mips_pkg::reg_idx_t i_rb_addr,
    input  wire [DM_ADDR_W-1:0]     i_dm_addr,
    output mips_pkg::data_t         o_rb_data,
    output mips_pkg::data_t         o_dm_data,
    output logic                    o_hlt
);
    import mips_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    wb_t      wb;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     stall;
    logic     hold;
    logic     flush;
    logic     branch_taken;
    logic     halt_in_id;
    data_t    branch_target;

    fetch_stage #(.IM_ADDR_W(IM_ADDR_W)) u_fetch_stage (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_stall(stall), .i_hold(hold), .i_flush(flush),
        .i_branch_target(branch_target),
        .i_im_we(i_im_we), .i_im_addr(i_im_addr), .i_im_data(i_im_data),
        .o_if_id(if_id)
    );

    decode_stage u_decode_stage (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_if_id(if_id), .i_wb(wb), .i_stall(stall), .i_flush(flush),
        .i_dbg_rb_addr(i_rb_addr),
        .o_id_ex(id_ex), .o_halt_in_id(halt_in_id), .o_dbg_rb_data(o_rb_data)
    );

    execute_stage u_execute_stage (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_id_ex(id_ex), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
        .i_wb(wb), .i_flush(flush),
        .o_ex_mem(ex_mem)
    );

    memory_stage #(.DM_ADDR_W(DM_ADDR_W)) u_memory_stage (
        .i_clock(i_clock), .i_arst_n(i_arst_n),
        .i_ex_mem(ex_mem), .i_dm_addr(i_dm_addr),
        .o_branch_taken(branch_taken), .o_branch_target(branch_target),
        .o_wb(wb), .o_hlt(o_hlt), .o_dm_data(o_dm_data)
    );

    hazard_unit u_hazard_unit (
        .i_if_id(if_id), .i_id_ex(id_ex), .i_ex_mem(ex_mem), .i_wb(wb),
        .i_branch_taken(branch_taken), .i_halt_in_id(halt_in_id),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
        .o_stall(stall), .o_hold(hold), .o_flush(flush)
    );

endmodule

`default_nettype wire

//--- tb/mips_pipeline_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module mips_pipeline_asserts (
    input wire                     i_clock,
    input wire                     i_arst_n,
    input wire                     i_stall,
    input wire                     i_flush,
    input wire mips_pkg::fwd_sel_e i_fwd_a,
    input wire mips_pkg::fwd_sel_e i_fwd_b,
    input wire mips_pkg::id_ex_t   i_id_ex
);
    import mips_pkg::*;

    int fail_count = 0;

    stall_single: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_stall |=> !i_stall)
        else begin
            fail_count++;
            $error("Load-use stall lasted two cycles");
        end

    flush_pulse: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_flush |=> !i_flush)
        else begin
            fail_count++;
            $error("Branch flush longer than one cycle");
        end

    // r0 is hardwired, never a forwarding target
    fwd_not_r0: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_fwd_a == FWD_NONE || i_id_ex.rs != '0) && (i_fwd_b == FWD_NONE || i_id_ex.rt != '0))
        else begin
            fail_count++;
            $error("Forwarding selected for register 0");
        end

endmodule

bind mips_pipeline mips_pipeline_asserts u_mips_pipeline_asserts (
    .i_clock  (i_clock),
    .i_arst_n (i_arst_n),
    .i_stall  (stall),
    .i_flush  (flush),
    .i_fwd_a  (fwd_a),
    .i_fwd_b  (fwd_b),
    .i_id_ex  (id_ex)
);

`default_nettype wire

//--- tb/tb_mips_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_pipeline;
    import mips_pkg::*;

    localparam int          IM_ADDR_W      = 8;
    localparam int          DM_ADDR_W      = 5;
    localparam int          CLK_PERIOD     = 20;
    localparam int          DRIVE_DLY      = 2;
    localparam int          RESET_CYCLES   = 16;
    localparam int          NUM_PROGS      = 4;
    localparam int          NUM_INSTR      = 48;
    localparam int          PROG_LEN       = NUM_INSTR + 1;   // Trailing HALT
    localparam int          TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 4 + 40);
    localparam logic [31:0] SEED           = 32'hcf8e7f9d;
    localparam data_t       HALT_WORD      = {OP_HALT, 26'd0};

    logic                 clock;
    logic                 arst_n;
    logic                 im_we;
    logic [IM_ADDR_W-1:0] im_addr;
    data_t                im_data;
    reg_idx_t             rb_addr;
    logic [DM_ADDR_W-1:0] dm_addr;
    data_t                rb_data;
    data_t                dm_data;
    logic                 hlt;

    data_t prog [PROG_LEN];
    data_t model_regs [32];
    data_t model_dmem [32];
    int    error_count;
    int    assert_fails;
    int    run_cycles;
    logic  running;

    mips_pipeline #(.IM_ADDR_W(IM_ADDR_W), .DM_ADDR_W(DM_ADDR_W)) u_mips_pipeline (
        .i_clock   (clock),
        .i_arst_n  (arst_n),
        .i_im_we   (im_we),
        .i_im_addr (im_addr),
        .i_im_data (im_data),
        .i_rb_addr (rb_addr),
        .i_dm_addr (dm_addr),
        .o_rb_data (rb_data),
        .o_dm_data (dm_data),
        .o_hlt     (hlt)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        if (running) begin
            run_cycles++;
            if (run_cycles > TIMEOUT_CYCLES) begin
                $display("Timeout: program did not halt within %0d cycles", TIMEOUT_CYCLES);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    end

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_halt(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    function automatic data_t rtype_word(input funct_e funct, input reg_idx_t rs,
                                         input reg_idx_t rt, input reg_idx_t rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic data_t itype_word(input opcode_e op, input reg_idx_t rs,
                                         input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic make_program();
        funct_e   functs [6] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT};
        int       kind;
        int       off;
        int       i;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        i = 0;
        while (i < NUM_INSTR) begin
            kind = $urandom_range(0, 9);
            rs   = reg_idx_t'($urandom_range(0, 7));
            rt   = reg_idx_t'($urandom_range(0, 7));
            rd   = reg_idx_t'($urandom_range(0, 7));
            off  = $urandom_range(1, 3);
            if (kind == 8 && i + 1 + off > NUM_INSTR) begin
                off = NUM_INSTR - i - 1;   // Target never past the final HALT
            end
            if ((kind == 8 && off == 0) || (kind == 9 && i + 2 > NUM_INSTR)) begin
                kind = 0;
            end
            case (kind)
                0, 1, 2, 3: prog[i] = rtype_word(functs[$urandom_range(0, 5)], rs, rt, rd);
                4, 5:       prog[i] = itype_word(OP_ADDI, rs, rt, 16'($urandom));
                6:          prog[i] = itype_word(OP_LW, 5'd0, rt, 16'($urandom_range(0, 31)));
                7:          prog[i] = itype_word(OP_SW, 5'd0, rt, 16'($urandom_range(0, 31)));
                8: begin
                    if ($urandom_range(0, 1) == 1) begin
                        rt = rs;   // Taken
                    end
                    prog[i] = itype_word(OP_BEQ, rs, rt, 16'(off));
                end
                default: begin
                    // HALT jumped over by an always-taken branch
                    prog[i] = itype_word(OP_BEQ, rs, rs, 16'd1);
                    i++;
                    prog[i] = HALT_WORD;
                end
            endcase
            i++;
        end
        prog[NUM_INSTR] = HALT_WORD;
    endtask

    task automatic run_model();
        int         pc;
        data_t      w;
        data_t      a;
        data_t      b;
        data_t      imm;
        data_t      res;
        logic [5:0] op;
        logic [5:0] funct;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
            model_dmem[r] = '0;
        end
        pc = 0;
        while (pc < PROG_LEN) begin
            w     = prog[pc];
            op    = w[31:26];
            rs    = w[25:21];
            rt    = w[20:16];
            rd    = w[15:11];
            funct = w[5:0];
            imm   = {{16{w[15]}}, w[15:0]};
            a     = model_regs[rs];
            b     = model_regs[rt];
            pc    = pc + 1;
            if (op == OP_HALT) begin
                break;
            end
            case (op)
                OP_RTYPE: begin
                    case (funct)
                        F_ADDU:  res = a + b;
                        F_SUBU:  res = a - b;
                        F_AND:   res = a & b;
                        F_OR:    res = a | b;
                        F_XOR:   res = a ^ b;
                        default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    if (rd != 0) begin
                        model_regs[rd] = res;
                    end
                end
                OP_ADDI: begin
                    if (rt != 0) begin
                        model_regs[rt] = a + imm;
                    end
                end
                OP_LW: begin
                    res = a + imm;
                    if (rt != 0) begin
                        model_regs[rt] = model_dmem[res[4:0]];
                    end
                end
                OP_SW: begin
                    res = a + imm;
                    model_dmem[res[4:0]] = b;
                end
                default: begin
                    if (a == b) begin
                        pc = pc + int'($signed(imm));   // BEQ relative to next word
                    end
                end
            endcase
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clock);
            #DRIVE_DLY;
            im_we   = 1'b1;
            im_addr = IM_ADDR_W'(i);
            im_data = prog[i];
        end
        @(posedge clock);
        #DRIVE_DLY;
        im_we = 1'b0;
    endtask

    task automatic check_state(input int prog_idx, input logic halted);
        string tag;
        tag = halted ? "final" : "reset";
        for (int addr = 0; addr < 32; addr++) begin
            @(posedge clock);
            #DRIVE_DLY;
            rb_addr = reg_idx_t'(addr);
            dm_addr = DM_ADDR_W'(addr);
            @(negedge clock);
            check_data($sformatf("prog%0d %s r%0d", prog_idx, tag, addr),
                       halted ? model_regs[addr] : data_t'(0), rb_data);
            check_data($sformatf("prog%0d %s dmem[%0d]", prog_idx, tag, addr),
                       halted ? model_dmem[addr] : data_t'(0), dm_data);
            check_halt($sformatf("prog%0d %s hlt", prog_idx, tag), halted, hlt);
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        im_we       = 1'b0;
        im_addr     = '0;
        im_data     = '0;
        rb_addr     = '0;
        dm_addr     = '0;
        running     = 1'b0;
        run_cycles  = 0;
        error_count = 0;
        void'($urandom(SEED));
        for (int p = 0; p < NUM_PROGS; p++) begin
            make_program();
            run_model();
            @(posedge clock);
            #DRIVE_DLY;
            arst_n = 1'b0;
            load_program();   // Instruction memory ignores reset
            repeat (RESET_CYCLES) @(posedge clock);
            check_state(p, 1'b0);
            @(posedge clock);
            #DRIVE_DLY;
            arst_n  = 1'b1;
            running = 1'b1;
            while (!hlt) @(negedge clock);
            running = 1'b0;
            check_state(p, 1'b1);
        end
        assert_fails = u_mips_pipeline.u_mips_pipeline_asserts.fail_count;
        $display("Errors: %0d check failures, %0d assertion failures",
                 error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/mips_pipeline.sv
tb/mips_pipeline_asserts.sv
tb/tb_mips_pipeline.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - files:
      - rtl/mips_pkg.sv
      - rtl/fetch_stage.sv
      - rtl/register_file.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/memory_stage.sv
      - rtl/hazard_unit.sv
      - rtl/mips_pipeline.sv
  - target: test
    files:
      - tb/mips_pipeline_asserts.sv
      - tb/tb_mips_pipeline.sv
